// ==== include/tap_defs.svh ====
// JTAG TAP controller constants
// Instruction length, IDCODE value, IR capture pattern
// and the opcode values of the supported instructions

`ifndef TAP_DEFS_SVH
`define TAP_DEFS_SVH

// Instruction register length in bits
`define TAP_IR_LEN 4

// Device identification, shifted out LSB first
`define TAP_IDCODE_VALUE 32'h149511C3

// Fixed capture pattern, 01 in the low bits as the standard asks
`define TAP_IR_CAPTURE 4'b0101

////////////////////////////////////////
// Opcodes
////////////////////////////////////////
`define TAP_OPC_EXTEST         4'b0000  // Boundary scan drives pins
`define TAP_OPC_SAMPLE_PRELOAD 4'b0001  // Boundary scan samples pins
`define TAP_OPC_IDCODE         4'b0010  // Default after reset
`define TAP_OPC_DEBUG          4'b1000  // Debug chain
`define TAP_OPC_MBIST          4'b1001  // Memory BIST chain
`define TAP_OPC_BYPASS         4'b1111  // All ones, mandatory

// Any code not listed above behaves as BYPASS

`endif

// ==== src/tap_pkg.sv ====
// JTAG TAP controller types
// TAP state and instruction enums
// Packed structs for state strobes, instruction selects
// and the TDO bits of the external chains

`include "tap_defs.svh"

package tap_pkg;

  // Binary state encoding, 4 flops
  typedef enum logic [3:0] {
    test_logic_reset = 4'hF,
    run_test_idle    = 4'hC,
    select_dr_scan   = 4'h7,
    capture_dr       = 4'h6,
    shift_dr         = 4'h2,
    exit1_dr         = 4'h1,
    pause_dr         = 4'h3,
    exit2_dr         = 4'h0,
    update_dr        = 4'h5,
    select_ir_scan   = 4'h4,
    capture_ir       = 4'hE,
    shift_ir         = 4'hA,
    exit1_ir         = 4'h9,
    pause_ir         = 4'hB,
    exit2_ir         = 4'h8,
    update_ir        = 4'hD
  } tap_state_e;

  // Instruction opcodes, values come from the defs header
  typedef enum logic [`TAP_IR_LEN-1:0] {
    EXTEST         = `TAP_OPC_EXTEST,
    SAMPLE_PRELOAD = `TAP_OPC_SAMPLE_PRELOAD,
    IDCODE         = `TAP_OPC_IDCODE,
    DEBUG          = `TAP_OPC_DEBUG,
    MBIST          = `TAP_OPC_MBIST,
    BYPASS         = `TAP_OPC_BYPASS
  } tap_instr_e;

  // One flag per decoded state, at most one set
  typedef struct packed {
    logic test_logic_reset;
    logic run_test_idle;
    logic capture_dr;
    logic shift_dr;
    logic pause_dr;
    logic update_dr;
    logic capture_ir;
    logic shift_ir;
    logic update_ir;
  } tap_strobe_t;

  // One-hot data register select
  typedef struct packed {
    logic extest;
    logic sample_preload;
    logic idcode;
    logic mbist;
    logic debug;
    logic bypass;
  } tap_sel_t;

  // Serial outputs of the chains outside the TAP
  typedef struct packed {
    logic debug;     // Debug unit
    logic bs_chain;  // Boundary scan
    logic mbist;     // Memory BIST
  } tap_ext_tdo_t;

endpackage

// ==== src/tap_fsm.sv ====
// TAP state machine
// Sixteen-state register stepped by TMS, next-state table
// and the combinational strobe decode

`timescale 1ns/100ps

module tap_fsm (
  input  logic                 dif,       // TCK
  input  logic                 rst_n_i,
  input  logic                 tms_i,
  output tap_pkg::tap_strobe_t strobe_o
);

  import tap_pkg::*;

  tap_state_e state_q;  // Current TAP state
  tap_state_e state_d;  // State after the next edge

  ////////////////////////////////////////
  // State register
  ////////////////////////////////////////
  always_ff @(posedge dif)
  begin
    if (!rst_n_i)
      state_q <= test_logic_reset;
    else
      state_q <= state_d;
  end

  // Standard IEEE 1149.1 transition table
  always_comb
  begin
    case (state_q)
      test_logic_reset: state_d = tms_i ? test_logic_reset : run_test_idle;
      run_test_idle:    state_d = tms_i ? select_dr_scan   : run_test_idle;
      select_dr_scan:   state_d = tms_i ? select_ir_scan   : capture_dr;
      capture_dr:       state_d = tms_i ? exit1_dr         : shift_dr;
      shift_dr:         state_d = tms_i ? exit1_dr         : shift_dr;
      exit1_dr:         state_d = tms_i ? update_dr        : pause_dr;
      pause_dr:         state_d = tms_i ? exit2_dr         : pause_dr;
      exit2_dr:         state_d = tms_i ? update_dr        : shift_dr;
      update_dr:        state_d = tms_i ? select_dr_scan   : run_test_idle;
      select_ir_scan:   state_d = tms_i ? test_logic_reset : capture_ir;  // IR branch or out
      capture_ir:       state_d = tms_i ? exit1_ir         : shift_ir;
      shift_ir:         state_d = tms_i ? exit1_ir         : shift_ir;
      exit1_ir:         state_d = tms_i ? update_ir        : pause_ir;
      pause_ir:         state_d = tms_i ? exit2_ir         : pause_ir;
      exit2_ir:         state_d = tms_i ? update_ir        : shift_ir;
      update_ir:        state_d = tms_i ? select_dr_scan   : run_test_idle;
      default:          state_d = test_logic_reset;  // Illegal code, recover
    endcase
  end

  ////////////////////////////////////////
  // Strobe decode
  ////////////////////////////////////////
  // Valid in the same cycle as the state
  always_comb
  begin
    strobe_o = '0;
    case (state_q)
      test_logic_reset: strobe_o.test_logic_reset = 1'b1;
      run_test_idle:    strobe_o.run_test_idle    = 1'b1;
      capture_dr:       strobe_o.capture_dr       = 1'b1;
      shift_dr:         strobe_o.shift_dr         = 1'b1;
      pause_dr:         strobe_o.pause_dr         = 1'b1;
      update_dr:        strobe_o.update_dr        = 1'b1;
      capture_ir:       strobe_o.capture_ir       = 1'b1;
      shift_ir:         strobe_o.shift_ir         = 1'b1;
      update_ir:        strobe_o.update_ir        = 1'b1;
      default:          strobe_o = '0;  // Select, exit and pause_ir states
    endcase
  end

endmodule

// ==== src/tap_ir.sv ====
// TAP instruction register
// Shift stage with fixed capture pattern, latched instruction
// and decode of the instruction to one-hot selects

`timescale 1ns/100ps

`include "tap_defs.svh"

module tap_ir (
  input  logic                 dif,       // TCK
  input  logic                 rst_n_i,
  input  logic                 tdi_i,
  input  tap_pkg::tap_strobe_t strobe_i,
  output logic                 ir_tdo_o,  // Serial out of the shift stage
  output tap_pkg::tap_sel_t    sel_o
);

  import tap_pkg::*;

  logic [`TAP_IR_LEN-1:0] ir_shift_q;  // Shift stage
  tap_instr_e             ir_latch_q;  // Active instruction

  ////////////////////////////////////////
  // Shift stage
  ////////////////////////////////////////
  always_ff @(posedge dif)
  begin
    if (!rst_n_i)
      ir_shift_q <= '0;
    else if (strobe_i.capture_ir)
      ir_shift_q <= `TAP_IR_CAPTURE;  // Known pattern shows up first on TDO
    else if (strobe_i.shift_ir)
      ir_shift_q <= {tdi_i, ir_shift_q[`TAP_IR_LEN-1:1]};  // TDI in at MSB
  end

  assign ir_tdo_o = ir_shift_q[0];

  ////////////////////////////////////////
  // Latched instruction
  ////////////////////////////////////////
  // Holds through the whole IR scan, changes only in update_ir
  always_ff @(posedge dif)
  begin
    if (!rst_n_i)
      ir_latch_q <= IDCODE;
    else if (strobe_i.test_logic_reset)
      ir_latch_q <= IDCODE;  // IDCODE is the default instruction
    else if (strobe_i.update_ir)
      ir_latch_q <= tap_instr_e'(ir_shift_q);
  end

  // Instruction decode, one bit set at any time
  always_comb
  begin
    sel_o = '0;
    case (ir_latch_q)
      EXTEST:         sel_o.extest         = 1'b1;
      SAMPLE_PRELOAD: sel_o.sample_preload = 1'b1;
      IDCODE:         sel_o.idcode         = 1'b1;
      MBIST:          sel_o.mbist          = 1'b1;
      DEBUG:          sel_o.debug          = 1'b1;
      BYPASS:         sel_o.bypass         = 1'b1;
      default:        sel_o.bypass         = 1'b1;  // Undefined codes act as BYPASS
    endcase
  end

endmodule

// ==== src/tap_data_regs.sv ====
// TAP internal data registers
// 32-bit IDCODE register and the 1-bit bypass register,
// both shifting LSB first toward TDO

`timescale 1ns/100ps

`include "tap_defs.svh"

module tap_data_regs (
  input  logic                 dif,           // TCK
  input  logic                 rst_n_i,
  input  logic                 tdi_i,
  input  tap_pkg::tap_strobe_t strobe_i,
  input  tap_pkg::tap_sel_t    sel_i,
  output logic                 idcode_tdo_o,
  output logic                 bypass_tdo_o
);

  logic [31:0] idcode_q;  // IDCODE shift register
  logic        bypass_q;  // Single bypass stage

  ////////////////////////////////////////
  // IDCODE
  ////////////////////////////////////////
  always_ff @(posedge dif)
  begin
    if (!rst_n_i)
      idcode_q <= `TAP_IDCODE_VALUE;
    else if (sel_i.idcode && strobe_i.capture_dr)
      idcode_q <= `TAP_IDCODE_VALUE;  // Reload for every DR scan
    else if (sel_i.idcode && strobe_i.shift_dr)
      idcode_q <= {tdi_i, idcode_q[31:1]};
  end

  assign idcode_tdo_o = idcode_q[0];

  ////////////////////////////////////////
  // Bypass
  ////////////////////////////////////////
  // Captures 0, then delays TDI by one shift
  always_ff @(posedge dif)
  begin
    if (!rst_n_i)
      bypass_q <= 1'b0;
    else if (sel_i.bypass && strobe_i.capture_dr)
      bypass_q <= 1'b0;
    else if (sel_i.bypass && strobe_i.shift_dr)
      bypass_q <= tdi_i;
  end

  assign bypass_tdo_o = bypass_q;

endmodule

// ==== src/tap_tdo_mux.sv ====
// TDO output stage
// Source select between IR, internal and external chains,
// registered TDO and its output enable

`timescale 1ns/100ps

module tap_tdo_mux (
  input  logic                  dif,       // TCK
  input  logic                  rst_n_i,
  input  tap_pkg::tap_strobe_t  strobe_i,
  input  tap_pkg::tap_sel_t     sel_i,
  input  logic                  ir_tdo_i,
  input  logic                  idcode_tdo_i,
  input  logic                  bypass_tdo_i,
  input  tap_pkg::tap_ext_tdo_t ext_tdo_i,
  output logic                  tdo_o,
  output logic                  tdo_oe_o
);

  logic tdo_d;  // Selected serial bit

  // IR scan overrides the instruction select
  always_comb
  begin
    if (strobe_i.shift_ir)
      tdo_d = ir_tdo_i;
    else if (sel_i.debug)
      tdo_d = ext_tdo_i.debug;
    else if (sel_i.extest || sel_i.sample_preload)
      tdo_d = ext_tdo_i.bs_chain;  // Both use the boundary scan chain
    else if (sel_i.mbist)
      tdo_d = ext_tdo_i.mbist;
    else if (sel_i.idcode)
      tdo_d = idcode_tdo_i;
    else
      tdo_d = bypass_tdo_i;
  end

  // Output flops, the pad sees the bit from before the shift edge
  always_ff @(posedge dif)
  begin
    if (!rst_n_i)
    begin
      tdo_o    <= 1'b0;
      tdo_oe_o <= 1'b0;
    end
    else
    begin
      tdo_o    <= tdo_d;
      tdo_oe_o <= strobe_i.shift_ir | strobe_i.shift_dr;  // Drive only while shifting
    end
  end

endmodule

// ==== src/tap_top.sv ====
// JTAG TAP controller top level
// State machine, instruction register, data registers
// and TDO output stage

`timescale 1ns/100ps

module tap_top (
  input  logic                  dif,        // TCK
  input  logic                  rst_n_i,    // Synchronous, replaces TRST
  input  logic                  tms_i,
  input  logic                  tdi_i,
  input  tap_pkg::tap_ext_tdo_t ext_tdo_i,  // From debug, boundary scan, MBIST
  output logic                  tdo_o,
  output logic                  tdo_oe_o,
  output tap_pkg::tap_strobe_t  strobe_o,   // State flags for the chains
  output tap_pkg::tap_sel_t     sel_o       // Active instruction, one-hot
);

  logic ir_tdo;      // IR shift stage LSB
  logic idcode_tdo;  // IDCODE register LSB
  logic bypass_tdo;  // Bypass stage

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////
  tap_fsm tap_fsm_inst (
    .dif      (dif),
    .rst_n_i  (rst_n_i),
    .tms_i    (tms_i),
    .strobe_o (strobe_o)
  );

  tap_ir tap_ir_inst (
    .dif      (dif),
    .rst_n_i  (rst_n_i),
    .tdi_i    (tdi_i),
    .strobe_i (strobe_o),
    .ir_tdo_o (ir_tdo),
    .sel_o    (sel_o)
  );

  ////////////////////////////////////////
  // Data path
  ////////////////////////////////////////
  tap_data_regs tap_data_regs_inst (
    .dif          (dif),
    .rst_n_i      (rst_n_i),
    .tdi_i        (tdi_i),
    .strobe_i     (strobe_o),
    .sel_i        (sel_o),
    .idcode_tdo_o (idcode_tdo),
    .bypass_tdo_o (bypass_tdo)
  );

  tap_tdo_mux tap_tdo_mux_inst (
    .dif          (dif),
    .rst_n_i      (rst_n_i),
    .strobe_i     (strobe_o),
    .sel_i        (sel_o),
    .ir_tdo_i     (ir_tdo),
    .idcode_tdo_i (idcode_tdo),
    .bypass_tdo_i (bypass_tdo),
    .ext_tdo_i    (ext_tdo_i),
    .tdo_o        (tdo_o),
    .tdo_oe_o     (tdo_oe_o)
  );

endmodule

// ==== test/tap_clk_gen.sv ====
// Testbench clock source
// Free running square wave, starts low

`timescale 1ns/100ps

module tap_clk_gen #(
  parameter int PERIOD_NS = 100  // Full clock period
) (
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;  // Half period per phase
  end

endmodule

// ==== test/tap_asserts.sv ====
// Concurrent protocol checks on the TAP top level
// One-hot instruction select, TDO enable timing and reset entry
// Bound into tap_top below the module

`timescale 1ns/100ps

module tap_asserts (
  input logic                 dif,       // TCK
  input logic                 rst_n_i,
  input logic                 tdo_oe_i,
  input tap_pkg::tap_strobe_t strobe_i,
  input tap_pkg::tap_sel_t    sel_i
);

  // Exactly one data register selected at any time
  sel_onehot_a: assert property (@(posedge dif) disable iff (!rst_n_i) $onehot(sel_i))
    else $error("sel_o is not one-hot (%b)", sel_i);

  // Pad driven only in the cycle after a shift state
  oe_after_shift_a: assert property (@(posedge dif) disable iff (!rst_n_i)
    tdo_oe_i |-> $past(strobe_i.shift_dr || strobe_i.shift_ir))
    else $error("tdo_oe_o high without a shift state one cycle before");

  // Synchronous reset lands in test_logic_reset
  reset_entry_a: assert property (@(posedge dif) !rst_n_i |=> strobe_i.test_logic_reset)
    else $error("state is not test_logic_reset after reset");

endmodule

bind tap_top tap_asserts tap_asserts_inst (
  .dif      (dif),
  .rst_n_i  (rst_n_i),
  .tdo_oe_i (tdo_oe_o),
  .strobe_i (strobe_o),
  .sel_i    (sel_o)
);

// ==== test/tap_tb.sv ====
// JTAG TAP controller testbench
// Directed scans for reset, IDCODE, IR capture, bypass and the
// external chains, then a random TMS walk against a reference model
// Falling-edge compare process, watchdog and closing report

`timescale 1ns/100ps

`include "tap_defs.svh"

module tap_tb;

  import tap_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int STIM_DELAY  = 10;   // Inputs change this long after the rising edge
  localparam int WALK_CYCLES = 500;
  // Reset, go idle, IDCODE scan, two bypass tests, four chain tests, walk, final reset
  localparam int PLANNED_CYCLES = 3 + 6 + 37 + 2 * 23 + 4 * 31 + WALK_CYCLES + 5;

  logic         dif;
  logic         rst_n_i;
  logic         tms_i;
  logic         tdi_i;
  tap_ext_tdo_t ext_tdo_i;
  logic         tdo_o;
  logic         tdo_oe_o;
  tap_strobe_t  strobe_o;
  tap_sel_t     sel_o;

  // Reference model state
  tap_state_e             ref_state;
  logic [`TAP_IR_LEN-1:0] ref_ir_shift;
  logic [`TAP_IR_LEN-1:0] ref_ir_latch;
  logic [31:0]            ref_idcode;
  logic                   ref_bypass;
  logic                   ref_tdo;
  logic                   ref_oe;
  logic                   model_valid = 1'b0;  // Set after the first modelled edge

  logic [`TAP_IR_LEN-1:0] active_opc;  // Instruction loaded by the directed tests

  int err_count   = 0;
  int check_count = 0;

  tap_clk_gen #(.PERIOD_NS(CLK_PERIOD)) clk_gen_inst (.clk_o(dif));

  tap_top tap_top_inst (
    .dif       (dif),
    .rst_n_i   (rst_n_i),
    .tms_i     (tms_i),
    .tdi_i     (tdi_i),
    .ext_tdo_i (ext_tdo_i),
    .tdo_o     (tdo_o),
    .tdo_oe_o  (tdo_oe_o),
    .strobe_o  (strobe_o),
    .sel_o     (sel_o)
  );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic tap_state_e next_tap_state(input tap_state_e s, input logic tms);
    case (s)
      test_logic_reset: return tms ? test_logic_reset : run_test_idle;
      run_test_idle:    return tms ? select_dr_scan : run_test_idle;
      select_dr_scan:   return tms ? select_ir_scan : capture_dr;
      capture_dr:       return tms ? exit1_dr : shift_dr;
      shift_dr:         return tms ? exit1_dr : shift_dr;
      exit1_dr:         return tms ? update_dr : pause_dr;
      pause_dr:         return tms ? exit2_dr : pause_dr;
      exit2_dr:         return tms ? update_dr : shift_dr;
      update_dr:        return tms ? select_dr_scan : run_test_idle;
      select_ir_scan:   return tms ? test_logic_reset : capture_ir;
      capture_ir:       return tms ? exit1_ir : shift_ir;
      shift_ir:         return tms ? exit1_ir : shift_ir;
      exit1_ir:         return tms ? update_ir : pause_ir;
      pause_ir:         return tms ? exit2_ir : pause_ir;
      exit2_ir:         return tms ? update_ir : shift_ir;
      default:          return tms ? select_dr_scan : run_test_idle;  // Update_ir
    endcase
  endfunction

  function automatic tap_sel_t decode_sel(input logic [`TAP_IR_LEN-1:0] code);
    tap_sel_t s;
    s = '0;
    case (code)
      `TAP_OPC_EXTEST:         s.extest         = 1'b1;
      `TAP_OPC_SAMPLE_PRELOAD: s.sample_preload = 1'b1;
      `TAP_OPC_IDCODE:         s.idcode         = 1'b1;
      `TAP_OPC_MBIST:          s.mbist          = 1'b1;
      `TAP_OPC_DEBUG:          s.debug          = 1'b1;
      default:                 s.bypass         = 1'b1;  // BYPASS and unknown codes
    endcase
    return s;
  endfunction

  function automatic tap_strobe_t expected_strobe(input tap_state_e s);
    tap_strobe_t f;
    f.test_logic_reset = (s == test_logic_reset);
    f.run_test_idle    = (s == run_test_idle);
    f.capture_dr       = (s == capture_dr);
    f.shift_dr         = (s == shift_dr);
    f.pause_dr         = (s == pause_dr);
    f.update_dr        = (s == update_dr);
    f.capture_ir       = (s == capture_ir);
    f.shift_ir         = (s == shift_ir);
    f.update_ir        = (s == update_ir);
    return f;
  endfunction

  // One rising edge of the TAP, all updates from the values before the edge
  function automatic void tap_ref_step(input logic rst_n, input logic tms, input logic tdi,
                                       input tap_ext_tdo_t ext);
    tap_sel_t s;
    s = decode_sel(ref_ir_latch);
    if (!rst_n)
    begin
      ref_state    = test_logic_reset;
      ref_ir_latch = `TAP_OPC_IDCODE;
      ref_ir_shift = '0;
      ref_idcode   = `TAP_IDCODE_VALUE;
      ref_bypass   = 1'b0;
      ref_tdo      = 1'b0;
      ref_oe       = 1'b0;
    end
    else
    begin
      if (ref_state == shift_ir)
        ref_tdo = ref_ir_shift[0];
      else if (s.debug)
        ref_tdo = ext.debug;
      else if (s.extest || s.sample_preload)
        ref_tdo = ext.bs_chain;
      else if (s.mbist)
        ref_tdo = ext.mbist;
      else if (s.idcode)
        ref_tdo = ref_idcode[0];
      else
        ref_tdo = ref_bypass;
      ref_oe = (ref_state == shift_ir) || (ref_state == shift_dr);
      if (ref_state == capture_ir)
        ref_ir_shift = `TAP_IR_CAPTURE;
      else if (ref_state == shift_ir)
        ref_ir_shift = {tdi, ref_ir_shift[`TAP_IR_LEN-1:1]};
      if (ref_state == test_logic_reset)
        ref_ir_latch = `TAP_OPC_IDCODE;
      else if (ref_state == update_ir)
        ref_ir_latch = ref_ir_shift;
      if (s.idcode && ref_state == capture_dr)
        ref_idcode = `TAP_IDCODE_VALUE;
      else if (s.idcode && ref_state == shift_dr)
        ref_idcode = {tdi, ref_idcode[31:1]};
      if (s.bypass && ref_state == capture_dr)
        ref_bypass = 1'b0;
      else if (s.bypass && ref_state == shift_dr)
        ref_bypass = tdi;
      ref_state = next_tap_state(ref_state, tms);
    end
  endfunction

  // Model sees the same inputs as the DUT at each edge
  always @(posedge dif)
  begin
    tap_ref_step(rst_n_i, tms_i, tdi_i, ext_tdo_i);
    model_valid = 1'b1;
  end

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp)
    else
    begin
      $display("ERR %s: got %h, expected %h at %0d ns", name, got, exp, $time);
      err_count++;
    end
  endtask

  // Falling edge is clear of both the DUT update and the input changes
  always @(negedge dif)
  begin
    if (model_valid)
    begin
      check_val("strobe_o", 32'(strobe_o), 32'(expected_strobe(ref_state)));
      check_val("sel_o", 32'(sel_o), 32'(decode_sel(ref_ir_latch)));
      check_val("tdo_o", 32'(tdo_o), 32'(ref_tdo));
      check_val("tdo_oe_o", 32'(tdo_oe_o), 32'(ref_oe));
    end
  end

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////
  task automatic drive(input logic tms, input logic tdi);
    tms_i = tms;
    tdi_i = tdi;
    @(posedge dif);
    #STIM_DELAY;  // Outputs of this edge are settled here
  endtask

  task automatic reset_by_tms();
    repeat (5) drive(1'b1, 1'b0);
    active_opc = `TAP_OPC_IDCODE;  // Test_logic_reset restores the default instruction
    check_val("strobe_o.test_logic_reset", 32'(strobe_o.test_logic_reset), 32'd1);
  endtask

  // Starts and ends in run_test_idle
  task automatic load_ir(input logic [`TAP_IR_LEN-1:0] opc, output logic [`TAP_IR_LEN-1:0] cap);
    drive(1'b1, 1'b0);  // Select_dr_scan
    drive(1'b1, 1'b0);  // Select_ir_scan
    drive(1'b0, 1'b0);  // Capture_ir
    drive(1'b0, 1'b0);  // Shift_ir holding the capture pattern
    for (int i = 0; i < `TAP_IR_LEN; i++)
    begin
      drive(i == `TAP_IR_LEN - 1, opc[i]);  // Last bit moves on to exit1_ir
      cap[i] = tdo_o;
    end
    drive(1'b1, 1'b0);  // Update_ir
    check_val("sel_o", 32'(sel_o), 32'(decode_sel(active_opc)));  // Old instruction still active
    drive(1'b0, 1'b0);
    active_opc = opc;
    check_val("sel_o", 32'(sel_o), 32'(decode_sel(opc)));
  endtask

  // Random ext_tdo_i per shift, eout keeps the bit picked by ext_idx
  task automatic scan_dr(input int n, input logic [31:0] din, input int ext_idx,
                         output logic [31:0] dout, output logic [31:0] eout);
    logic [31:0] rnd;
    dout = '0;
    eout = '0;
    drive(1'b1, 1'b0);  // Select_dr_scan
    drive(1'b0, 1'b0);  // Capture_dr
    drive(1'b0, 1'b0);  // Shift_dr with the capture loaded
    for (int i = 0; i < n; i++)
    begin
      rnd       = $urandom();
      ext_tdo_i = rnd[2:0];
      eout[i]   = rnd[ext_idx];
      drive(i == n - 1, din[i]);
      dout[i] = tdo_o;
      check_val("tdo_oe_o", 32'(tdo_oe_o), 32'd1);  // High on every shift
    end
    drive(1'b1, 1'b0);  // Update_dr
    drive(1'b0, 1'b0);  // Run_test_idle
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial
  begin
    logic [31:0]            din;
    logic [31:0]            dout;
    logic [31:0]            eout;
    logic [31:0]            rnd;
    logic [`TAP_IR_LEN-1:0] cap;
    logic [`TAP_IR_LEN-1:0] ext_opc [4];
    int                     ext_idx [4];

    void'($urandom(37796));
    ext_opc   = '{`TAP_OPC_DEBUG, `TAP_OPC_MBIST, `TAP_OPC_EXTEST, `TAP_OPC_SAMPLE_PRELOAD};
    ext_idx   = '{2, 0, 1, 1};  // Bit of tap_ext_tdo_t behind each opcode
    rst_n_i   = 1'b0;
    tms_i     = 1'b1;
    tdi_i     = 1'b0;
    ext_tdo_i = '0;
    repeat (3) @(posedge dif);
    #STIM_DELAY;
    rst_n_i = 1'b1;

    check_val("strobe_o.test_logic_reset", 32'(strobe_o.test_logic_reset), 32'd1);
    check_val("sel_o.idcode", 32'(sel_o.idcode), 32'd1);
    check_val("tdo_oe_o", 32'(tdo_oe_o), 32'd0);
    reset_by_tms();
    drive(1'b0, 1'b0);  // Run_test_idle

    // IDCODE comes out LSB first
    scan_dr(32, $urandom(), 0, dout, eout);
    check_val("tdo_o (IDCODE scan)", dout, `TAP_IDCODE_VALUE);

    load_ir(`TAP_OPC_BYPASS, cap);
    check_val("tdo_o (IR capture)", 32'(cap), 32'(`TAP_IR_CAPTURE));
    din = $urandom();
    scan_dr(8, din, 0, dout, eout);
    check_val("tdo_o (BYPASS)", 32'(dout[7:0]), 32'({din[6:0], 1'b0}));

    load_ir(4'b0011, cap);  // Undefined code
    check_val("sel_o.bypass", 32'(sel_o.bypass), 32'd1);
    din = $urandom();
    scan_dr(8, din, 0, dout, eout);
    check_val("tdo_o (undefined code)", 32'(dout[7:0]), 32'({din[6:0], 1'b0}));

    foreach (ext_opc[k])
    begin
      load_ir(ext_opc[k], cap);
      scan_dr(16, $urandom(), ext_idx[k], dout, eout);
      check_val("tdo_o (external chain)", 32'(dout[15:0]), 32'(eout[15:0]));
    end

    repeat (WALK_CYCLES)
    begin
      rnd       = $urandom();
      ext_tdo_i = rnd[4:2];
      drive(rnd[0], rnd[1]);
    end
    reset_by_tms();  // From wherever the walk ended

    $display("Checks done with %0d errors in %0d checks", err_count, check_count);
    if (err_count == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // Watchdog sized from the planned cycle count
  initial
  begin
    #((PLANNED_CYCLES + 200) * CLK_PERIOD);
    $display("Timeout: the test sequence did not finish in time");
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+include
src/tap_pkg.sv
src/tap_fsm.sv
src/tap_ir.sv
src/tap_data_regs.sv
src/tap_tdo_mux.sv
src/tap_top.sv
test/tap_clk_gen.sv
test/tap_asserts.sv
test/tap_tb.sv

// ==== Makefile ====
# Verilator build and run of the TAP controller testbench

TOP = tap_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

# Fails on a simulator error status or on the fail message in the log
run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" sim.log; then exit 1; fi

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
